//--- list.f
hdl/net_cfg_pkg.sv
hdl/net_ctrl_pkg.sv
hdl/hold_qualifier.sv
hdl/tcp_session_fsm.sv
hdl/transfer_sequencer.sv
hdl/network_cent_ctrl.sv
tests/network_cent_ctrl_assertions.sv
tests/network_cent_ctrl_checker.sv
tests/network_cent_ctrl_tb.sv

//--- Makefile
# Verilator build and run of the network central controller testbench

TOP := network_cent_ctrl_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert --timing --timescale 1ns/100ps -f list.f --top-module $(TOP)

# pass only when the run prints the pass line
run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TESTBENCH PASSED"

lint:
	verilator --lint-only --timing --timescale 1ns/100ps -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir

//--- tests/network_cent_ctrl_tb.sv
/*
 * testbench for the network central controller: clock, reset,
 * table of stimulus rows with expected outputs, and watchdog
 */
module network_cent_ctrl_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int clk_period = 8;

    // short settle and timeout counts keep the run small
    localparam logic [net_cfg_pkg::count_width-1:0] link_settle   = 20;
    localparam logic [net_cfg_pkg::count_width-1:0] msg_settle    = 6;
    localparam logic [net_cfg_pkg::count_width-1:0] reply_timeout = 30;

    logic clk_PP;
    logic reset;
    logic link_status;
    logic msg_stored;
    logic tx_busy;
    logic tx_pending;
    logic ack_confirmed;
    logic rx_busy;
    logic received_valid;
    logic is_handshake;
    logic need_ack;
    net_ctrl_pkg::tcp_state_t tcp_state;
    logic msg_ready;
    logic transfer_en;
    logic block_tx;
    logic block_rx;

    // expected values handed to the checker
    logic check_en;
    int   row_index;
    net_ctrl_pkg::tcp_state_t exp_state;
    logic exp_transfer_en;
    logic exp_block_tx;
    logic exp_block_rx;
    logic exp_msg_ready;
    int   error_count;
    int   check_count;

    // table columns, one entry per row
    logic [6:0] row_levels[$];
    logic [1:0] row_strobes[$];
    int         row_cycles[$];
    net_ctrl_pkg::tcp_state_t row_state[$];
    logic [3:0] row_outs[$];

    logic [31:0] lfsr = 32'hc4577d75;
    int          watchdog_ns = 0;

    network_cent_ctrl #(
        .link_settle   (link_settle),
        .msg_settle    (msg_settle),
        .reply_timeout (reply_timeout)
    ) i_dut (
        .clk_PP         (clk_PP),
        .reset          (reset),
        .link_status    (link_status),
        .msg_stored     (msg_stored),
        .tx_busy        (tx_busy),
        .tx_pending     (tx_pending),
        .ack_confirmed  (ack_confirmed),
        .rx_busy        (rx_busy),
        .received_valid (received_valid),
        .is_handshake   (is_handshake),
        .need_ack       (need_ack),
        .tcp_state      (tcp_state),
        .msg_ready      (msg_ready),
        .transfer_en    (transfer_en),
        .block_tx       (block_tx),
        .block_rx       (block_rx)
    );

    network_cent_ctrl_checker i_checker (
        .clk_PP          (clk_PP),
        .check_en        (check_en),
        .row_index       (row_index),
        .exp_state       (exp_state),
        .exp_transfer_en (exp_transfer_en),
        .exp_block_tx    (exp_block_tx),
        .exp_block_rx    (exp_block_rx),
        .exp_msg_ready   (exp_msg_ready),
        .tcp_state       (tcp_state),
        .transfer_en     (transfer_en),
        .block_tx        (block_tx),
        .block_rx        (block_rx),
        .msg_ready       (msg_ready),
        .error_count     (error_count),
        .check_count     (check_count)
    );

    bind transfer_sequencer network_cent_ctrl_assertions i_assertions (
        .clk_PP      (clk_PP),
        .reset       (reset),
        .tcp_state   (tcp_state),
        .seq_state   (state),
        .transfer_en (transfer_en),
        .block_tx    (block_tx),
        .block_rx    (block_rx)
    );

    initial clk_PP = 1'b0;
    always #(clk_period / 2) clk_PP = ~clk_PP;

    // ----------------------------------------
    // helpers
    // ----------------------------------------

    // fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // glitch of 1 to 5 cycles from three LFSR bits
    task automatic pick_glitch(output int len);
        int value;
        value = 0;
        repeat (3) begin
            lfsr = lfsr_step(lfsr);
            value = (value << 1) | int'(lfsr[0]);
        end
        len = 1 + (value % 5);
    endtask

    task automatic add_row(input logic [6:0] levels, input logic [1:0] strobes,
                           input int cycles, input net_ctrl_pkg::tcp_state_t state,
                           input logic [3:0] outs);
        row_levels.push_back(levels);
        row_strobes.push_back(strobes);
        row_cycles.push_back(cycles);
        row_state.push_back(state);
        row_outs.push_back(outs);
    endtask

    // levels  link msg tx_busy tx_pending rx_busy is_handshake need_ack
    // strobes received_valid ack_confirmed
    // outs    transfer_en block_tx block_rx msg_ready
    task automatic build_table();
        int glitch;
        add_row(7'b0000000, 2'b00, 2, net_ctrl_pkg::tcp_disconnect, 4'b0100);
        // msg_stored glitches never qualify
        repeat (4) begin
            pick_glitch(glitch);
            add_row(7'b0100000, 2'b00, glitch, net_ctrl_pkg::tcp_disconnect, 4'b0100);
            add_row(7'b0000000, 2'b00, 2, net_ctrl_pkg::tcp_disconnect, 4'b0100);
        end
        add_row(7'b0100000, 2'b00, 10, net_ctrl_pkg::tcp_disconnect, 4'b0101);
        add_row(7'b0000000, 2'b00, 3, net_ctrl_pkg::tcp_disconnect, 4'b0100);
        // link too short, then long enough
        add_row(7'b1000000, 2'b00, 15, net_ctrl_pkg::tcp_disconnect, 4'b0100);
        add_row(7'b0000000, 2'b00, 4, net_ctrl_pkg::tcp_disconnect, 4'b0100);
        add_row(7'b1000000, 2'b00, 25, net_ctrl_pkg::tcp_handshake0, 4'b1010);
        // opening handshake
        add_row(7'b1010000, 2'b00, 3, net_ctrl_pkg::tcp_handshake0, 4'b0010);
        add_row(7'b1000000, 2'b00, 3, net_ctrl_pkg::tcp_handshake0, 4'b0100);
        add_row(7'b1000100, 2'b00, 2, net_ctrl_pkg::tcp_handshake0, 4'b0000);
        add_row(7'b1000110, 2'b10, 2, net_ctrl_pkg::tcp_handshake1, 4'b0100);
        add_row(7'b1000000, 2'b00, 4, net_ctrl_pkg::tcp_handshake1, 4'b1010);
        add_row(7'b1010000, 2'b00, 3, net_ctrl_pkg::tcp_handshake1, 4'b0010);
        add_row(7'b1000000, 2'b00, 4, net_ctrl_pkg::tcp_transfer, 4'b0100);
        // data out, reply never comes, retransmit
        add_row(7'b1001000, 2'b00, 4, net_ctrl_pkg::tcp_transfer, 4'b1010);
        add_row(7'b1011000, 2'b00, 3, net_ctrl_pkg::tcp_transfer, 4'b0010);
        add_row(7'b1001000, 2'b00, 40, net_ctrl_pkg::tcp_transfer, 4'b1010);
        // resent data gets its ack
        add_row(7'b1011000, 2'b00, 3, net_ctrl_pkg::tcp_transfer, 4'b0010);
        add_row(7'b1001000, 2'b00, 3, net_ctrl_pkg::tcp_transfer, 4'b0100);
        add_row(7'b1001100, 2'b00, 2, net_ctrl_pkg::tcp_transfer, 4'b0000);
        add_row(7'b1001100, 2'b10, 4, net_ctrl_pkg::tcp_transfer, 4'b0000);
        add_row(7'b1000100, 2'b01, 3, net_ctrl_pkg::tcp_transfer, 4'b0100);
        add_row(7'b1000000, 2'b00, 3, net_ctrl_pkg::tcp_transfer, 4'b0100);
        // peer data wants an ack from us
        add_row(7'b1000101, 2'b10, 3, net_ctrl_pkg::tcp_ack_send, 4'b1010);
        add_row(7'b1010000, 2'b00, 3, net_ctrl_pkg::tcp_ack_send, 4'b0010);
        add_row(7'b1000000, 2'b00, 4, net_ctrl_pkg::tcp_transfer, 4'b0100);
    endtask

    // levels and strobes at a rising edge, strobes dropped one edge later
    task automatic run_row(input int idx);
        @(posedge clk_PP);
        check_en <= 1'b0;
        {link_status, msg_stored, tx_busy, tx_pending, rx_busy, is_handshake,
         need_ack} <= row_levels[idx];
        {received_valid, ack_confirmed} <= row_strobes[idx];
        @(posedge clk_PP);
        received_valid <= 1'b0;
        ack_confirmed  <= 1'b0;
        repeat (row_cycles[idx] - 1) @(posedge clk_PP);
        exp_state <= row_state[idx];
        {exp_transfer_en, exp_block_tx, exp_block_rx, exp_msg_ready} <= row_outs[idx];
        row_index <= idx;
        check_en  <= 1'b1;
    endtask

    // ----------------------------------------
    // watchdog
    // ----------------------------------------

    initial begin : watchdog
        wait (watchdog_ns > 0);
        #(watchdog_ns);
        $display("timeout: the row sequence did not finish within %0d ns", watchdog_ns);
        $display("TESTBENCH FAILED");
        $finish;
    end

    // ----------------------------------------
    // main sequence
    // ----------------------------------------

    initial begin : main
        int total_cycles;
        int assert_fails;
        reset           = 1'b1;
        link_status     = 1'b0;
        msg_stored      = 1'b0;
        tx_busy         = 1'b0;
        tx_pending      = 1'b0;
        ack_confirmed   = 1'b0;
        rx_busy         = 1'b0;
        received_valid  = 1'b0;
        is_handshake    = 1'b0;
        need_ack        = 1'b0;
        check_en        = 1'b0;
        row_index       = 0;
        exp_state       = net_ctrl_pkg::tcp_disconnect;
        exp_transfer_en = 1'b0;
        exp_block_tx    = 1'b0;
        exp_block_rx    = 1'b0;
        exp_msg_ready   = 1'b0;
        build_table();
        total_cycles = 0;
        foreach (row_cycles[i]) begin
            total_cycles += row_cycles[i] + 1;
        end
        // reset, the closing edge and some slack
        watchdog_ns = (total_cycles + 64) * clk_period;
        repeat (2) @(posedge clk_PP);
        reset <= 1'b0;
        foreach (row_cycles[i]) begin
            run_row(i);
        end
        @(posedge clk_PP);
        check_en <= 1'b0;
        assert_fails = i_dut.i_sequencer.i_assertions.fail_count;
        $display("rows %0d, checks %0d, mismatches %0d, assertion failures %0d",
                 row_cycles.size(), check_count, error_count, assert_fails);
        if ((error_count == 0) && (assert_fails == 0) && (check_count == row_cycles.size())) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- tests/network_cent_ctrl_checker.sv
/*
 * output checker that compares DUT outputs with a row's expected values
 * at the falling edge after the row ends, and counts errors
 */
module network_cent_ctrl_checker (
    input  logic                     clk_PP,
    input  logic                     check_en,
    input  int                       row_index,
    // expected values of the current row
    input  net_ctrl_pkg::tcp_state_t exp_state,
    input  logic                     exp_transfer_en,
    input  logic                     exp_block_tx,
    input  logic                     exp_block_rx,
    input  logic                     exp_msg_ready,
    // DUT outputs
    input  net_ctrl_pkg::tcp_state_t tcp_state,
    input  logic                     transfer_en,
    input  logic                     block_tx,
    input  logic                     block_rx,
    input  logic                     msg_ready,
    output int                       error_count,
    output int                       check_count
);
    timeunit 1ns;
    timeprecision 100ps;

    int errors = 0;
    int checks = 0;

    assign error_count = errors;
    assign check_count = checks;

    // ----------------------------------------
    // single field compare
    // ----------------------------------------

    task automatic compare_field(input string name, input logic [2:0] actual,
                                 input logic [2:0] expected);
        if (actual !== expected) begin
            errors = errors + 1;
            $display("mismatch at %0d ns, row %0d: %s is %b, expected %b",
                     $time, row_index, name, actual, expected);
        end
    endtask

    // ----------------------------------------
    // row end compare
    // ----------------------------------------

    // outputs settled since the rising edge
    always @(negedge clk_PP) begin
        if (check_en) begin
            checks = checks + 1;
            compare_field("tcp_state", tcp_state, exp_state);
            compare_field("transfer_en", {2'b00, transfer_en}, {2'b00, exp_transfer_en});
            compare_field("block_tx", {2'b00, block_tx}, {2'b00, exp_block_tx});
            compare_field("block_rx", {2'b00, block_rx}, {2'b00, exp_block_rx});
            compare_field("msg_ready", {2'b00, msg_ready}, {2'b00, exp_msg_ready});
        end
    end

endmodule

//--- tests/network_cent_ctrl_assertions.sv
/*
 * sequencer and session invariants, bound into the transfer sequencer
 */
module network_cent_ctrl_assertions (
    input logic                      clk_PP,
    input logic                      reset,
    input net_ctrl_pkg::tcp_state_t  tcp_state,
    input net_ctrl_pkg::xfer_state_t seq_state,
    input logic                      transfer_en,
    input logic                      block_tx,
    input logic                      block_rx
);
    timeunit 1ns;
    timeprecision 100ps;

    // failed assertions, read by the testbench top
    int fail_count = 0;

    // ----------------------------------------
    // path blocking
    // ----------------------------------------

    // never both paths blocked at once
    a_block_exclusive: assert property (@(posedge clk_PP) disable iff (reset)
        !(block_tx && block_rx))
    else begin
        fail_count++;
        $error("block_tx and block_rx high in the same cycle");
    end

    // enable only follows send, so RX stays blocked
    a_enable_blocks_rx: assert property (@(posedge clk_PP) disable iff (reset)
        transfer_en |-> block_rx)
    else begin
        fail_count++;
        $error("transfer_en high while block_rx is low");
    end

    // ----------------------------------------
    // session coupling
    // ----------------------------------------

    a_idle_when_down: assert property (@(posedge clk_PP) disable iff (reset)
        (tcp_state == net_ctrl_pkg::tcp_disconnect) |-> (seq_state == net_ctrl_pkg::xfer_idle))
    else begin
        fail_count++;
        $error("sequencer left idle while the session is disconnected");
    end

endmodule

//--- hdl/network_cent_ctrl.sv
/*
 * network central controller: link and message qualifiers, TCP session FSM
 * and transfer sequencer of a point-to-point TCP-over-GMII link
 */
module network_cent_ctrl #(
    parameter logic [net_cfg_pkg::count_width-1:0] link_settle   =
        net_cfg_pkg::link_settle_default,
    parameter logic [net_cfg_pkg::count_width-1:0] msg_settle    =
        net_cfg_pkg::msg_settle_default,
    parameter logic [net_cfg_pkg::count_width-1:0] reply_timeout =
        net_cfg_pkg::reply_timeout_default
) (
    input  logic                     clk_PP,
    input  logic                     reset,
    // PHY and host levels
    input  logic                     link_status,
    input  logic                     msg_stored,
    // frame generator status
    input  logic                     tx_busy,
    input  logic                     tx_pending,
    input  logic                     ack_confirmed,
    // frame sniffer status
    input  logic                     rx_busy,
    input  logic                     received_valid,
    input  logic                     is_handshake,
    input  logic                     need_ack,
    output net_ctrl_pkg::tcp_state_t tcp_state,
    output logic                     msg_ready,
    output logic                     transfer_en,
    output logic                     block_tx,
    output logic                     block_rx
);

    // stable link from the PHY
    logic link_up;
    // segment handed off by the generator
    logic tx_sent;

    // ----------------------------------------
    // input qualifiers
    // ----------------------------------------

    hold_qualifier #(
        .width       (net_cfg_pkg::count_width),
        .hold_cycles (link_settle)
    ) i_link_qual (
        .clk_PP    (clk_PP),
        .reset     (reset),
        .level     (link_status),
        .qualified (link_up)
    );

    hold_qualifier #(
        .width       (net_cfg_pkg::count_width),
        .hold_cycles (msg_settle)
    ) i_msg_qual (
        .clk_PP    (clk_PP),
        .reset     (reset),
        .level     (msg_stored),
        .qualified (msg_ready)
    );

    // ----------------------------------------
    // session and sequencer
    // ----------------------------------------

    tcp_session_fsm i_session (
        .clk_PP         (clk_PP),
        .reset          (reset),
        .link_up        (link_up),
        .received_valid (received_valid),
        .is_handshake   (is_handshake),
        .need_ack       (need_ack),
        .tx_sent        (tx_sent),
        .tcp_state      (tcp_state)
    );

    transfer_sequencer #(
        .reply_timeout (reply_timeout)
    ) i_sequencer (
        .clk_PP         (clk_PP),
        .reset          (reset),
        .tcp_state      (tcp_state),
        .tx_busy        (tx_busy),
        .tx_pending     (tx_pending),
        .rx_busy        (rx_busy),
        .received_valid (received_valid),
        .is_handshake   (is_handshake),
        .need_ack       (need_ack),
        .ack_confirmed  (ack_confirmed),
        .transfer_en    (transfer_en),
        .block_tx       (block_tx),
        .block_rx       (block_rx),
        .tx_sent        (tx_sent)
    );

endmodule

//--- hdl/transfer_sequencer.sv
/*
 * transfer sequencer: paces one exchange, blocks the TX or RX path and
 * retransmits when the reply does not come within reply_timeout cycles
 */
module transfer_sequencer #(
    parameter logic [net_cfg_pkg::count_width-1:0] reply_timeout = '1
) (
    input  logic                     clk_PP,
    input  logic                     reset,
    input  net_ctrl_pkg::tcp_state_t tcp_state,
    input  logic                     tx_busy,
    input  logic                     tx_pending,
    input  logic                     rx_busy,
    input  logic                     received_valid,
    input  logic                     is_handshake,
    input  logic                     need_ack,
    input  logic                     ack_confirmed,
    output logic                     transfer_en,
    output logic                     block_tx,
    output logic                     block_rx,
    output logic                     tx_sent
);

    net_ctrl_pkg::xfer_state_t state;
    net_ctrl_pkg::xfer_state_t state_next;

    // reply wait counter, only runs in wait-rx
    logic [net_cfg_pkg::count_width-1:0] lost_cnt;
    logic                                reply_lost;

    // session wants to send data of ours
    logic data_to_send;

    assign data_to_send = (tcp_state == net_ctrl_pkg::tcp_transfer) && tx_pending;
    assign reply_lost   = (lost_cnt >= reply_timeout);

    // ----------------------------------------
    // state register
    // ----------------------------------------

    always_ff @(posedge clk_PP or posedge reset) begin
        if (reset) begin
            state <= net_ctrl_pkg::xfer_idle;
        end else begin
            state <= state_next;
        end
    end

    // ----------------------------------------
    // next state
    // ----------------------------------------

    always_comb begin
        state_next = state;
        if (tcp_state == net_ctrl_pkg::tcp_disconnect) begin
            // no session, nothing to sequence
            state_next = net_ctrl_pkg::xfer_idle;
        end else begin
            case (state)
                net_ctrl_pkg::xfer_idle: begin
                    if (!tx_busy) begin
                        case (tcp_state)
                            net_ctrl_pkg::tcp_handshake0,
                            net_ctrl_pkg::tcp_handshake1,
                            net_ctrl_pkg::tcp_ack_send: begin
                                state_next = net_ctrl_pkg::xfer_send;
                            end
                            net_ctrl_pkg::tcp_transfer: begin
                                if (tx_pending) begin
                                    state_next = net_ctrl_pkg::xfer_send;
                                end
                            end
                            default: begin
                                state_next = state;
                            end
                        endcase
                    end
                end
                net_ctrl_pkg::xfer_send: begin
                    // data went away before the generator started
                    if ((tcp_state == net_ctrl_pkg::tcp_transfer) && !data_to_send) begin
                        state_next = net_ctrl_pkg::xfer_idle;
                    end else if (tx_busy) begin
                        state_next = net_ctrl_pkg::xfer_wait_tx;
                    end
                end
                net_ctrl_pkg::xfer_wait_tx: begin
                    if (!tx_busy) begin
                        case (tcp_state)
                            // these segments expect a reply
                            net_ctrl_pkg::tcp_handshake0,
                            net_ctrl_pkg::tcp_transfer: begin
                                state_next = net_ctrl_pkg::xfer_wait_rx;
                            end
                            default: begin
                                state_next = net_ctrl_pkg::xfer_idle;
                            end
                        endcase
                    end
                end
                net_ctrl_pkg::xfer_wait_rx: begin
                    if (rx_busy) begin
                        state_next = net_ctrl_pkg::xfer_check_reply;
                    end else if (reply_lost) begin
                        // retransmit the same segment
                        state_next = net_ctrl_pkg::xfer_send;
                    end
                end
                net_ctrl_pkg::xfer_check_reply: begin
                    if (received_valid) begin
                        if (is_handshake || need_ack || !tx_pending) begin
                            state_next = net_ctrl_pkg::xfer_wait_rx_last;
                        end else begin
                            state_next = net_ctrl_pkg::xfer_wait_ack;
                        end
                    end else if (!rx_busy) begin
                        // frame dropped by the sniffer
                        state_next = net_ctrl_pkg::xfer_idle;
                    end
                end
                net_ctrl_pkg::xfer_wait_ack: begin
                    if (ack_confirmed) begin
                        state_next = net_ctrl_pkg::xfer_wait_rx_last;
                    end
                end
                net_ctrl_pkg::xfer_wait_rx_last: begin
                    if (!rx_busy) begin
                        state_next = net_ctrl_pkg::xfer_idle;
                    end
                end
                default: begin
                    state_next = net_ctrl_pkg::xfer_idle;
                end
            endcase
        end
    end

    // ----------------------------------------
    // reply timeout
    // ----------------------------------------

    always_ff @(posedge clk_PP or posedge reset) begin
        if (reset) begin
            lost_cnt <= '0;
        end else if (state != net_ctrl_pkg::xfer_wait_rx) begin
            lost_cnt <= '0;
        end else if (!reply_lost) begin
            lost_cnt <= lost_cnt + 1'b1;
        end
    end

    // ----------------------------------------
    // outputs
    // ----------------------------------------

    // one cycle behind the send state
    always_ff @(posedge clk_PP or posedge reset) begin
        if (reset) begin
            transfer_en <= 1'b0;
        end else begin
            transfer_en <= (state == net_ctrl_pkg::xfer_send);
        end
    end

    // generator done with our segment, leaves wait-tx next edge
    assign tx_sent = (state == net_ctrl_pkg::xfer_wait_tx) && !tx_busy;

    // path blocking, plain state decode
    assign block_tx = (state == net_ctrl_pkg::xfer_idle)
                   || (state == net_ctrl_pkg::xfer_wait_rx)
                   || (state == net_ctrl_pkg::xfer_wait_rx_last);
    assign block_rx = (state == net_ctrl_pkg::xfer_send)
                   || (state == net_ctrl_pkg::xfer_wait_tx);

endmodule

//--- hdl/tcp_session_fsm.sv
/*
 * TCP session FSM, initiating side: handshake, transfer and ack send
 */
module tcp_session_fsm (
    input  logic                    clk_PP,
    input  logic                    reset,
    input  logic                    link_up,
    input  logic                    received_valid,
    input  logic                    is_handshake,
    input  logic                    need_ack,
    input  logic                    tx_sent,
    output net_ctrl_pkg::tcp_state_t tcp_state
);

    net_ctrl_pkg::tcp_state_t state_next;

    // received frame classes
    logic rx_handshake;
    logic rx_data_ack;

    assign rx_handshake = received_valid && is_handshake;
    assign rx_data_ack  = received_valid && !is_handshake && need_ack;

    // ----------------------------------------
    // state register
    // ----------------------------------------

    always_ff @(posedge clk_PP or posedge reset) begin
        if (reset) begin
            tcp_state <= net_ctrl_pkg::tcp_disconnect;
        end else begin
            tcp_state <= state_next;
        end
    end

    // ----------------------------------------
    // next state
    // ----------------------------------------

    always_comb begin
        state_next = tcp_state;
        case (tcp_state)
            net_ctrl_pkg::tcp_disconnect: begin
                // we open the session as soon as the PHY is stable
                if (link_up) begin
                    state_next = net_ctrl_pkg::tcp_handshake0;
                end
            end
            net_ctrl_pkg::tcp_handshake0: begin
                // peer answered our opening segment
                if (rx_handshake) begin
                    state_next = net_ctrl_pkg::tcp_handshake1;
                end
            end
            net_ctrl_pkg::tcp_handshake1: begin
                // closing segment went out
                if (tx_sent) begin
                    state_next = net_ctrl_pkg::tcp_transfer;
                end
            end
            net_ctrl_pkg::tcp_transfer: begin
                // peer repeats its handshake, so ours got lost
                if (rx_handshake) begin
                    state_next = net_ctrl_pkg::tcp_handshake1;
                end else if (rx_data_ack) begin
                    state_next = net_ctrl_pkg::tcp_ack_send;
                end
            end
            net_ctrl_pkg::tcp_ack_send: begin
                if (tx_sent) begin
                    state_next = net_ctrl_pkg::tcp_transfer;
                end
            end
            default: begin
                // unused codes fall back to a clean start
                state_next = net_ctrl_pkg::tcp_disconnect;
            end
        endcase
    end

endmodule

//--- hdl/hold_qualifier.sv
/*
 * hold qualifier: output goes high once the input level has held for
 * hold_cycles consecutive cycles, and drops with the input
 */
module hold_qualifier #(
    parameter int               width       = 28,
    parameter logic [width-1:0] hold_cycles = '1
) (
    input  logic clk_PP,
    input  logic reset,
    input  logic level,
    output logic qualified
);

    // cycles the input has been high, saturating
    logic [width-1:0] hold_cnt;

    // ----------------------------------------
    // hold counter
    // ----------------------------------------

    always_ff @(posedge clk_PP or posedge reset) begin
        if (reset) begin
            hold_cnt <= '0;
        end else if (!level) begin
            // any low cycle restarts the count
            hold_cnt <= '0;
        end else if (hold_cnt < hold_cycles) begin
            hold_cnt <= hold_cnt + 1'b1;
        end
    end

    // ----------------------------------------
    // qualified output
    // ----------------------------------------

    // level term lets the output drop one edge after the input does
    always_ff @(posedge clk_PP or posedge reset) begin
        if (reset) begin
            qualified <= 1'b0;
        end else begin
            qualified <= level && (hold_cnt == hold_cycles);
        end
    end

endmodule

//--- hdl/net_ctrl_pkg.sv
/*
 * controller state encodings for the TCP session and the transfer sequencer
 */
package net_ctrl_pkg;

    // ----------------------------------------
    // TCP session, initiating side
    // ----------------------------------------

    typedef enum logic [2:0] {
        // waiting for a qualified link
        tcp_disconnect = 3'd0,
        // our opening segment out, waiting for the peer reply
        tcp_handshake0 = 3'd1,
        // reply seen, closing segment to send
        tcp_handshake1 = 3'd2,
        // session open, data both ways
        tcp_transfer   = 3'd3,
        // peer data needs an ack from us
        tcp_ack_send   = 3'd4
    } tcp_state_t;

    // ----------------------------------------
    // per-exchange transfer sequencer
    // ----------------------------------------

    // gray-ish coding along the main send/reply path
    typedef enum logic [2:0] {
        xfer_idle         = 3'b000,
        xfer_send         = 3'b001,
        xfer_wait_tx      = 3'b011,
        xfer_wait_rx      = 3'b010,
        // sniffer busy, deciding what the reply was
        xfer_check_reply  = 3'b111,
        // our data sent, waiting for its ack
        xfer_wait_ack     = 3'b100,
        // let the sniffer finish the frame
        xfer_wait_rx_last = 3'b101
    } xfer_state_t;

endpackage

//--- hdl/net_cfg_pkg.sv
/*
 * controller configuration: counter width and default settle and timeout counts
 */
package net_cfg_pkg;

    // ----------------------------------------
    // widths
    // ----------------------------------------

    // settle and reply-timeout counters share one width
    localparam int count_width = 28;

    // ----------------------------------------
    // default cycle counts
    // ----------------------------------------

    // PHY must report link up this long, 26 bits of ones
    localparam logic [count_width-1:0] link_settle_default = 28'h3ff_ffff;

    // host message-stored level hold time
    localparam logic [count_width-1:0] msg_settle_default = 28'd1000;

    // reply wait before retransmit, 2^27 - 1
    localparam logic [count_width-1:0] reply_timeout_default = 28'h7ff_ffff;

endpackage
